// ==== design/cache_bus_pkg.sv ====
// Memory bus definitions
package cache_bus_pkg;

	// Address and data path
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 32;

	// Byte offset inside a word
	localparam int BYTE_OFF_BITS = $clog2(DATA_BITS / 8);

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [DATA_BITS-1:0] word_t;

	// A line fill is one wrapping burst over the whole line
	localparam int FILL_BEATS = 4;

	// Read length field carries beats minus one
	localparam int LEN_BITS = $clog2(FILL_BEATS);

	typedef logic [LEN_BITS-1:0] len_t;

	// Length encodings for the two kinds of read command
	localparam len_t LEN_FILL = len_t'(FILL_BEATS - 1);
	localparam len_t LEN_SINGLE = len_t'(0);

endpackage

// ==== design/cache_cfg_pkg.sv ====
// Cache geometry and stored entries
package cache_cfg_pkg;

	import cache_bus_pkg::*;

	// Line layout
	localparam int LINE_WORDS = 4;
	localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);

	// 256 sets, so one way covers a 4 KB page
	localparam int SET_BITS = 8;

	// Address split as tag | set | word | byte
	localparam int SET_LSB = BYTE_OFF_BITS + WORD_SEL_BITS;
	localparam int TAG_LSB = SET_LSB + SET_BITS;
	localparam int TAG_BITS = ADDR_BITS - TAG_LSB;

	// Valid flag sits above the tag in a stored entry
	localparam int TAG_VALID = TAG_BITS;

	typedef logic [LINE_WORDS*DATA_BITS-1:0] line_t;
	typedef logic [TAG_BITS:0] tag_entry_t;
	typedef logic [SET_BITS-1:0] set_idx_t;
	typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

endpackage

// ==== design/sram_dualport.sv ====
// Two-port synchronous RAM
`timescale 1ns/1ps

module sram_dualport #(
	parameter type payload_t = logic [31:0],
	parameter int ADDR_W = 8,
	parameter bit CLEAR_ON_RESET = 1'b0
) (
	input logic clk_i,
	input logic rst_n,
	input logic i_we_a,
	input logic [ADDR_W-1:0] i_addr_a,
	input payload_t i_wdata_a,
	output payload_t o_rdata_a,
	input logic i_we_b,
	input logic [ADDR_W-1:0] i_addr_b,
	input payload_t i_wdata_b,
	output payload_t o_rdata_b
);

	localparam int DEPTH = 2 ** ADDR_W;

	payload_t mem [DEPTH];
	payload_t rdata_a_q;
	payload_t rdata_b_q;
	logic live_a_q;
	logic live_b_q;

	// Read returns the old contents, and port A wins an address collision
	always_ff @(posedge clk_i) begin
		if (i_we_b) begin
			mem[i_addr_b] <= i_wdata_b;
		end
		if (i_we_a) begin
			mem[i_addr_a] <= i_wdata_a;
		end
		rdata_a_q <= mem[i_addr_a];
		rdata_b_q <= mem[i_addr_b];
	end

	generate
		if (CLEAR_ON_RESET) begin : g_clear
			// One bit per address, so the whole array clears in a single cycle
			logic [DEPTH-1:0] written_q;

			always_ff @(posedge clk_i) begin
				if (!rst_n) begin
					written_q <= '0;
					live_a_q <= 1'b0;
					live_b_q <= 1'b0;
				end else begin
					if (i_we_a) begin
						written_q[i_addr_a] <= 1'b1;
					end
					if (i_we_b) begin
						written_q[i_addr_b] <= 1'b1;
					end
					live_a_q <= written_q[i_addr_a];
					live_b_q <= written_q[i_addr_b];
				end
			end
		end else begin : g_plain
			assign live_a_q = 1'b1;
			assign live_b_q = 1'b1;
		end
	endgenerate

	// Never written since reset reads as zero
	assign o_rdata_a = live_a_q ? rdata_a_q : '0;
	assign o_rdata_b = live_b_q ? rdata_b_q : '0;

	a_no_write_clash: assert property (@(posedge clk_i) disable iff (!rst_n)
		!(i_we_a && i_we_b && (i_addr_a == i_addr_b)))
		else $error("both ports write address %0h", i_addr_a);

endmodule

// ==== design/way_lookup.sv ====
// Parallel tag compare across ways
`timescale 1ns/1ps

module way_lookup
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int CACHE_WAYS = 4,
	localparam int WAY_W = $clog2(CACHE_WAYS)
) (
	input logic [TAG_BITS-1:0] i_tag,
	input word_sel_t i_word,
	input tag_entry_t i_entries [CACHE_WAYS],
	input line_t i_lines [CACHE_WAYS],
	output logic o_hit,
	output logic [WAY_W-1:0] o_hit_way,
	output logic o_free_valid,
	output logic [WAY_W-1:0] o_free_way,
	output word_t o_hit_word
);

	logic [CACHE_WAYS-1:0] match;
	line_t hit_line;

	always_comb begin
		for (int w = 0; w < CACHE_WAYS; w++) begin
			match[w] = i_entries[w][TAG_VALID] && (i_entries[w][TAG_BITS-1:0] == i_tag);
		end
	end

	// Walk down so the lowest matching or invalid way is the one kept
	always_comb begin
		o_hit_way = '0;
		o_free_valid = 1'b0;
		o_free_way = '0;
		for (int w = CACHE_WAYS - 1; w >= 0; w--) begin
			if (match[w]) begin
				o_hit_way = WAY_W'(w);
			end
			if (!i_entries[w][TAG_VALID]) begin
				o_free_valid = 1'b1;
				o_free_way = WAY_W'(w);
			end
		end
	end

	assign o_hit = |match;

	// Word select out of the hitting line
	assign hit_line = i_lines[o_hit_way];
	assign o_hit_word = hit_line[i_word*DATA_BITS +: DATA_BITS];

	// A line is only ever filled on a miss, so a tag lives in one way at most
	always_comb begin
		if (!$isunknown(match)) begin
			a_single_hit: assert ($onehot0(match))
				else $error("multiple ways hit, match=%0h", match);
		end
	end

endmodule

// ==== design/snoop_invalidate.sv ====
// Snoop invalidation through tag port B
`timescale 1ns/1ps

module snoop_invalidate
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int CACHE_WAYS = 4,
	localparam int WAY_W = $clog2(CACHE_WAYS)
) (
	input logic clk_i,
	input logic rst_n,
	input logic i_snoop_valid,
	input addr_t i_snoop_addr,
	output logic o_snoop_busy,
	output set_idx_t o_tag_addr,
	output logic [TAG_BITS-1:0] o_lookup_tag,
	output logic [CACHE_WAYS-1:0] o_tag_we,
	output tag_entry_t o_tag_wdata,
	input logic i_hit,
	input logic [WAY_W-1:0] i_hit_way
);

	typedef enum logic [1:0] {
		SN_WAIT,
		SN_READ,
		SN_COMPARE
	} snoop_state_e;

	snoop_state_e state_q;
	addr_t snoop_addr_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= SN_WAIT;
		end else begin
			case (state_q)
				SN_WAIT: begin
					if (i_snoop_valid) begin
						state_q <= SN_READ;
					end
				end
				SN_READ: state_q <= SN_COMPARE;
				SN_COMPARE: state_q <= SN_WAIT;
				default: state_q <= SN_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == SN_WAIT && i_snoop_valid) begin
			snoop_addr_q <= i_snoop_addr;
		end
	end

	assign o_snoop_busy = (state_q != SN_WAIT);

	// Present the incoming set straight away so the tags are out by the read state
	assign o_tag_addr = (state_q == SN_WAIT) ? i_snoop_addr[TAG_LSB-1:SET_LSB]
		: snoop_addr_q[TAG_LSB-1:SET_LSB];
	assign o_lookup_tag = snoop_addr_q[ADDR_BITS-1:TAG_LSB];

	// Clear the whole entry of the matching way
	always_comb begin
		for (int w = 0; w < CACHE_WAYS; w++) begin
			o_tag_we[w] = (state_q == SN_COMPARE) && i_hit && (i_hit_way == WAY_W'(w));
		end
	end
	assign o_tag_wdata = '0;

	a_snoop_spacing: assert property (@(posedge clk_i) disable iff (!rst_n)
		o_snoop_busy |-> !i_snoop_valid)
		else $error("snoop strobed while busy, addr=%08h", i_snoop_addr);

endmodule

// ==== design/rw_controller.sv ====
// Request FSM for hits, fills and write-through
`timescale 1ns/1ps

module rw_controller
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int CACHE_WAYS = 4,
	localparam int WAY_W = $clog2(CACHE_WAYS)
) (
	input logic clk_i,
	input logic rst_n,
	input logic i_req_valid,
	input logic i_req_write,
	input logic i_req_cacheable,
	input addr_t i_req_addr,
	input word_t i_req_wdata,
	output logic o_req_ready,
	output logic o_rsp_valid,
	output word_t o_rsp_rdata,
	output logic o_mem_rd_valid,
	output addr_t o_mem_rd_addr,
	output len_t o_mem_rd_len,
	input logic i_mem_rd_ready,
	input logic i_mem_rdata_valid,
	input word_t i_mem_rdata,
	output logic o_mem_wr_valid,
	output addr_t o_mem_wr_addr,
	output word_t o_mem_wr_data,
	input logic i_mem_wr_ready,
	input logic i_mem_wr_ack,
	input logic i_snoop_busy,
	output set_idx_t o_ram_addr,
	output logic [TAG_BITS-1:0] o_lookup_tag,
	output word_sel_t o_lookup_word,
	output logic [CACHE_WAYS-1:0] o_tag_we,
	output logic [CACHE_WAYS-1:0] o_data_we,
	output tag_entry_t o_tag_wdata,
	output line_t o_data_wdata,
	input line_t i_line_rdata [CACHE_WAYS],
	input logic i_hit,
	input logic [WAY_W-1:0] i_hit_way,
	input logic i_free_valid,
	input logic [WAY_W-1:0] i_free_way,
	input word_t i_hit_word
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_COMPARE,
		ST_HIT_RSP,
		ST_FILL_CMD,
		ST_FILL_DATA,
		ST_LINE_WRITE,
		ST_WR_CMD,
		ST_WR_ACK,
		ST_UNC_CMD,
		ST_UNC_DATA
	} rw_state_e;

	rw_state_e state_q;
	logic rsp_valid_q;
	logic wr_hit_q;
	logic [WAY_W-1:0] way_q;
	logic [WAY_W-1:0] rr_q;
	len_t beat_q;

	// Request payload and line buffer
	addr_t addr_q;
	word_t wdata_q;
	logic write_q;
	word_t rsp_rdata_q;
	line_t line_q;
	line_t merged_line;
	word_sel_t word_idx;
	word_sel_t fill_word;
	addr_t word_addr;
	logic req_fire;

	assign o_req_ready = (state_q == ST_IDLE) && !i_snoop_busy;
	assign req_fire = i_req_valid && o_req_ready;

	assign word_idx = addr_q[SET_LSB-1 -: WORD_SEL_BITS];
	assign word_addr = {addr_q[ADDR_BITS-1:BYTE_OFF_BITS], {BYTE_OFF_BITS{1'b0}}};

	// Wrap order, starting at the requested word
	assign fill_word = word_sel_t'(word_idx + beat_q);

	always_comb begin
		merged_line = i_line_rdata[i_hit_way];
		merged_line[word_idx*DATA_BITS +: DATA_BITS] = wdata_q;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			rsp_valid_q <= 1'b0;
			wr_hit_q <= 1'b0;
			way_q <= '0;
			rr_q <= '0;
			beat_q <= '0;
		end else begin
			// Round-robin victim for sets with every way valid
			rr_q <= rr_q + 1'b1;
			rsp_valid_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (req_fire) begin
						state_q <= (!i_req_write && !i_req_cacheable) ? ST_UNC_CMD : ST_LOOKUP;
					end
				end
				ST_LOOKUP: state_q <= ST_COMPARE;
				ST_COMPARE: begin
					wr_hit_q <= i_hit;
					way_q <= i_hit ? i_hit_way : (i_free_valid ? i_free_way : rr_q);
					if (write_q) begin
						state_q <= ST_WR_CMD;
					end else if (i_hit) begin
						rsp_valid_q <= 1'b1;
						state_q <= ST_HIT_RSP;
					end else begin
						state_q <= ST_FILL_CMD;
					end
				end
				ST_HIT_RSP: state_q <= ST_IDLE;
				ST_FILL_CMD: begin
					beat_q <= '0;
					if (i_mem_rd_ready) begin
						state_q <= ST_FILL_DATA;
					end
				end
				ST_FILL_DATA: begin
					if (i_mem_rdata_valid) begin
						beat_q <= beat_q + 1'b1;
						// Critical word goes back to the requester at once
						if (beat_q == '0) begin
							rsp_valid_q <= 1'b1;
						end
						if (beat_q == LEN_FILL) begin
							state_q <= ST_LINE_WRITE;
						end
					end
				end
				ST_LINE_WRITE: state_q <= ST_IDLE;
				ST_WR_CMD: begin
					if (i_mem_wr_ready) begin
						state_q <= ST_WR_ACK;
					end
				end
				ST_WR_ACK: begin
					if (i_mem_wr_ack) begin
						rsp_valid_q <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				ST_UNC_CMD: begin
					if (i_mem_rd_ready) begin
						state_q <= ST_UNC_DATA;
					end
				end
				ST_UNC_DATA: begin
					if (i_mem_rdata_valid) begin
						rsp_valid_q <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_fire) begin
			addr_q <= i_req_addr;
			wdata_q <= i_req_wdata;
			write_q <= i_req_write;
		end
		if (state_q == ST_COMPARE) begin
			rsp_rdata_q <= i_hit_word;
			line_q <= merged_line;
		end
		if ((state_q == ST_FILL_DATA || state_q == ST_UNC_DATA) && i_mem_rdata_valid) begin
			if (state_q == ST_UNC_DATA || beat_q == '0) begin
				rsp_rdata_q <= i_mem_rdata;
			end
			line_q[fill_word*DATA_BITS +: DATA_BITS] <= i_mem_rdata;
		end
	end

	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp_rdata = rsp_rdata_q;

	assign o_ram_addr = addr_q[TAG_LSB-1:SET_LSB];
	assign o_lookup_tag = addr_q[ADDR_BITS-1:TAG_LSB];
	assign o_lookup_word = word_idx;

	// Fill writes tag and line, a write hit rewrites only the merged line
	always_comb begin
		for (int w = 0; w < CACHE_WAYS; w++) begin
			o_tag_we[w] = (state_q == ST_LINE_WRITE) && (way_q == WAY_W'(w));
			o_data_we[w] = (way_q == WAY_W'(w)) && ((state_q == ST_LINE_WRITE)
				|| (state_q == ST_WR_CMD && i_mem_wr_ready && wr_hit_q));
		end
	end
	assign o_tag_wdata = {1'b1, o_lookup_tag};
	assign o_data_wdata = line_q;

	assign o_mem_rd_valid = (state_q == ST_FILL_CMD) || (state_q == ST_UNC_CMD);
	assign o_mem_rd_addr = word_addr;
	assign o_mem_rd_len = (state_q == ST_FILL_CMD) ? LEN_FILL : LEN_SINGLE;

	assign o_mem_wr_valid = (state_q == ST_WR_CMD);
	assign o_mem_wr_addr = word_addr;
	assign o_mem_wr_data = wdata_q;

	// Read beats only arrive inside a read burst, so a fill stops at FILL_BEATS
	a_fill_beats: assert property (@(posedge clk_i) disable iff (!rst_n)
		i_mem_rdata_valid |-> (state_q == ST_FILL_DATA || state_q == ST_UNC_DATA))
		else $error("read beat outside a burst, state=%0d", state_q);

endmodule

// ==== design/l1_cache_top.sv ====
// L1 cache top level
`timescale 1ns/1ps

module l1_cache_top
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int CACHE_WAYS = 4,
	localparam int WAY_W = $clog2(CACHE_WAYS)
) (
	input logic clk_i,
	input logic rst_n,
	input logic i_req_valid,
	input logic i_req_write,
	input logic i_req_cacheable,
	input addr_t i_req_addr,
	input word_t i_req_wdata,
	output logic o_req_ready,
	output logic o_rsp_valid,
	output word_t o_rsp_rdata,
	output logic o_mem_rd_valid,
	output addr_t o_mem_rd_addr,
	output len_t o_mem_rd_len,
	input logic i_mem_rd_ready,
	input logic i_mem_rdata_valid,
	input word_t i_mem_rdata,
	output logic o_mem_wr_valid,
	output addr_t o_mem_wr_addr,
	output word_t o_mem_wr_data,
	input logic i_mem_wr_ready,
	input logic i_mem_wr_ack,
	input logic i_snoop_valid,
	input addr_t i_snoop_addr,
	output logic o_snoop_busy
);

	// Port A side, owned by the request FSM
	set_idx_t ram_addr;
	logic [CACHE_WAYS-1:0] tag_we_a;
	logic [CACHE_WAYS-1:0] data_we_a;
	tag_entry_t tag_wdata_a;
	line_t data_wdata_a;
	tag_entry_t tag_rdata_a [CACHE_WAYS];
	line_t data_rdata_a [CACHE_WAYS];
	logic [TAG_BITS-1:0] req_tag;
	word_sel_t req_word;
	logic req_hit;
	logic [WAY_W-1:0] req_hit_way;
	logic req_free_valid;
	logic [WAY_W-1:0] req_free_way;
	word_t req_hit_word;

	// Port B side, owned by the snoop unit
	set_idx_t snoop_tag_addr;
	logic [CACHE_WAYS-1:0] tag_we_b;
	tag_entry_t tag_wdata_b;
	tag_entry_t tag_rdata_b [CACHE_WAYS];
	logic [TAG_BITS-1:0] snoop_tag;
	logic snoop_hit;
	logic [WAY_W-1:0] snoop_hit_way;

	for (genvar w = 0; w < CACHE_WAYS; w++) begin : g_way
		sram_dualport #(
			.payload_t(tag_entry_t),
			.ADDR_W(SET_BITS),
			.CLEAR_ON_RESET(1'b1)
		) u_tag (
			.clk_i(clk_i),
			.rst_n(rst_n),
			.i_we_a(tag_we_a[w]),
			.i_addr_a(ram_addr),
			.i_wdata_a(tag_wdata_a),
			.o_rdata_a(tag_rdata_a[w]),
			.i_we_b(tag_we_b[w]),
			.i_addr_b(snoop_tag_addr),
			.i_wdata_b(tag_wdata_b),
			.o_rdata_b(tag_rdata_b[w])
		);

		// Line data is only reached through port A
		sram_dualport #(
			.payload_t(line_t),
			.ADDR_W(SET_BITS)
		) u_data (
			.clk_i(clk_i),
			.rst_n(rst_n),
			.i_we_a(data_we_a[w]),
			.i_addr_a(ram_addr),
			.i_wdata_a(data_wdata_a),
			.o_rdata_a(data_rdata_a[w]),
			.i_we_b(1'b0),
			.i_addr_b('0),
			.i_wdata_b('0),
			.o_rdata_b()
		);
	end

	way_lookup #(.CACHE_WAYS(CACHE_WAYS)) u_req_lookup (
		.i_tag(req_tag),
		.i_word(req_word),
		.i_entries(tag_rdata_a),
		.i_lines(data_rdata_a),
		.o_hit(req_hit),
		.o_hit_way(req_hit_way),
		.o_free_valid(req_free_valid),
		.o_free_way(req_free_way),
		.o_hit_word(req_hit_word)
	);

	way_lookup #(.CACHE_WAYS(CACHE_WAYS)) u_snoop_lookup (
		.i_tag(snoop_tag),
		.i_word('0),
		.i_entries(tag_rdata_b),
		.i_lines(data_rdata_a),
		.o_hit(snoop_hit),
		.o_hit_way(snoop_hit_way),
		.o_free_valid(),
		.o_free_way(),
		.o_hit_word()
	);

	rw_controller #(.CACHE_WAYS(CACHE_WAYS)) u_rw (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_req_valid(i_req_valid),
		.i_req_write(i_req_write),
		.i_req_cacheable(i_req_cacheable),
		.i_req_addr(i_req_addr),
		.i_req_wdata(i_req_wdata),
		.o_req_ready(o_req_ready),
		.o_rsp_valid(o_rsp_valid),
		.o_rsp_rdata(o_rsp_rdata),
		.o_mem_rd_valid(o_mem_rd_valid),
		.o_mem_rd_addr(o_mem_rd_addr),
		.o_mem_rd_len(o_mem_rd_len),
		.i_mem_rd_ready(i_mem_rd_ready),
		.i_mem_rdata_valid(i_mem_rdata_valid),
		.i_mem_rdata(i_mem_rdata),
		.o_mem_wr_valid(o_mem_wr_valid),
		.o_mem_wr_addr(o_mem_wr_addr),
		.o_mem_wr_data(o_mem_wr_data),
		.i_mem_wr_ready(i_mem_wr_ready),
		.i_mem_wr_ack(i_mem_wr_ack),
		.i_snoop_busy(o_snoop_busy),
		.o_ram_addr(ram_addr),
		.o_lookup_tag(req_tag),
		.o_lookup_word(req_word),
		.o_tag_we(tag_we_a),
		.o_data_we(data_we_a),
		.o_tag_wdata(tag_wdata_a),
		.o_data_wdata(data_wdata_a),
		.i_line_rdata(data_rdata_a),
		.i_hit(req_hit),
		.i_hit_way(req_hit_way),
		.i_free_valid(req_free_valid),
		.i_free_way(req_free_way),
		.i_hit_word(req_hit_word)
	);

	snoop_invalidate #(.CACHE_WAYS(CACHE_WAYS)) u_snoop (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_snoop_valid(i_snoop_valid),
		.i_snoop_addr(i_snoop_addr),
		.o_snoop_busy(o_snoop_busy),
		.o_tag_addr(snoop_tag_addr),
		.o_lookup_tag(snoop_tag),
		.o_tag_we(tag_we_b),
		.o_tag_wdata(tag_wdata_b),
		.i_hit(snoop_hit),
		.i_hit_way(snoop_hit_way)
	);

endmodule

// ==== tests/tb_mem_model.sv ====
// Behavioral memory for the cache testbench
`timescale 1ns/1ps

module tb_mem_model
	import cache_bus_pkg::*;
(
	input logic clk_i,
	input logic i_rd_valid,
	input addr_t i_rd_addr,
	input len_t i_rd_len,
	output logic o_rd_ready,
	output logic o_rdata_valid,
	output word_t o_rdata,
	input logic i_wr_valid,
	input addr_t i_wr_addr,
	input word_t i_wr_data,
	output logic o_wr_ready,
	output logic o_wr_ack,
	output int o_rd_bursts,
	output int o_wr_count
);

	// Unwritten words hold their own address with this pattern mixed in
	localparam word_t INIT_XOR = 32'h5a5a_0000;
	localparam int LINE_BYTES = FILL_BEATS * DATA_BITS / 8;

	word_t mem [addr_t];

	function automatic word_t read_word(input addr_t addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		return addr ^ INIT_XOR;
	endfunction

	// Wrap order keeps every beat inside the line of the first address
	function automatic addr_t beat_addr(input addr_t start, input int beat);
		addr_t base;
		addr_t offset;
		base = start & ~addr_t'(LINE_BYTES - 1);
		offset = (start - base + addr_t'(beat * DATA_BITS / 8)) % addr_t'(LINE_BYTES);
		return base + offset;
	endfunction

	// Read commands get a random ready delay and then their beats back to back
	initial begin
		addr_t start;
		len_t len;
		o_rd_ready <= 1'b0;
		o_rdata_valid <= 1'b0;
		o_rdata <= '0;
		o_rd_bursts <= 0;
		forever begin
			@(posedge clk_i);
			if (i_rd_valid) begin
				repeat ($urandom_range(3, 0)) @(posedge clk_i);
				o_rd_ready <= 1'b1;
				@(posedge clk_i);
				o_rd_ready <= 1'b0;
				start = i_rd_addr;
				len = i_rd_len;
				o_rd_bursts <= o_rd_bursts + 1;
				repeat ($urandom_range(2, 0)) @(posedge clk_i);
				for (int beat = 0; beat <= int'(len); beat++) begin
					o_rdata_valid <= 1'b1;
					o_rdata <= read_word(beat_addr(start, beat));
					@(posedge clk_i);
				end
				o_rdata_valid <= 1'b0;
			end
		end
	end

	// Write words land at the handshake and the ack follows later
	initial begin
		o_wr_ready <= 1'b0;
		o_wr_ack <= 1'b0;
		o_wr_count <= 0;
		forever begin
			@(posedge clk_i);
			if (i_wr_valid) begin
				repeat ($urandom_range(3, 0)) @(posedge clk_i);
				o_wr_ready <= 1'b1;
				@(posedge clk_i);
				o_wr_ready <= 1'b0;
				mem[i_wr_addr] = i_wr_data;
				o_wr_count <= o_wr_count + 1;
				repeat ($urandom_range(3, 0)) @(posedge clk_i);
				o_wr_ack <= 1'b1;
				@(posedge clk_i);
				o_wr_ack <= 1'b0;
			end
		end
	end

endmodule

// ==== tests/tb_l1_cache.sv ====
// L1 cache testbench
`timescale 1ns/1ps

module tb_l1_cache
	import cache_bus_pkg::*;
();

	localparam int CACHE_WAYS = 4;
	localparam int CLK_PERIOD = 10;
	localparam logic [31:0] SEED = 32'hfa67_c448;
	localparam int MAX_OPS = 64;
	localparam int COLS = 5;
	localparam int CYCLES_PER_OP = 200;
	localparam int HIT_LATENCY = 3;
	localparam logic [31:0] OP_READ = 32'd0;
	localparam logic [31:0] OP_WRITE = 32'd1;
	localparam logic [31:0] OP_UNCACHED = 32'd2;
	localparam logic [31:0] OP_SNOOP = 32'd3;
	localparam logic [31:0] END_MARK = 32'hffff_ffff;

	logic clk_i;
	logic rst_n;
	logic req_valid;
	logic req_write;
	logic req_cacheable;
	addr_t req_addr;
	word_t req_wdata;
	logic req_ready;
	logic rsp_valid;
	word_t rsp_rdata;
	logic mem_rd_valid;
	addr_t mem_rd_addr;
	len_t mem_rd_len;
	logic mem_rd_ready;
	logic mem_rdata_valid;
	word_t mem_rdata;
	logic mem_wr_valid;
	addr_t mem_wr_addr;
	word_t mem_wr_data;
	logic mem_wr_ready;
	logic mem_wr_ack;
	logic snoop_valid;
	addr_t snoop_addr;
	logic snoop_busy;
	int rd_bursts;
	int wr_count;

	logic [31:0] op_table [MAX_OPS * COLS];
	int num_ops = 0;
	int op_idx = 0;
	int checks_done = 0;

	l1_cache_top #(.CACHE_WAYS(CACHE_WAYS)) u_dut (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_req_valid(req_valid),
		.i_req_write(req_write),
		.i_req_cacheable(req_cacheable),
		.i_req_addr(req_addr),
		.i_req_wdata(req_wdata),
		.o_req_ready(req_ready),
		.o_rsp_valid(rsp_valid),
		.o_rsp_rdata(rsp_rdata),
		.o_mem_rd_valid(mem_rd_valid),
		.o_mem_rd_addr(mem_rd_addr),
		.o_mem_rd_len(mem_rd_len),
		.i_mem_rd_ready(mem_rd_ready),
		.i_mem_rdata_valid(mem_rdata_valid),
		.i_mem_rdata(mem_rdata),
		.o_mem_wr_valid(mem_wr_valid),
		.o_mem_wr_addr(mem_wr_addr),
		.o_mem_wr_data(mem_wr_data),
		.i_mem_wr_ready(mem_wr_ready),
		.i_mem_wr_ack(mem_wr_ack),
		.i_snoop_valid(snoop_valid),
		.i_snoop_addr(snoop_addr),
		.o_snoop_busy(snoop_busy)
	);

	tb_mem_model u_mem (
		.clk_i(clk_i),
		.i_rd_valid(mem_rd_valid),
		.i_rd_addr(mem_rd_addr),
		.i_rd_len(mem_rd_len),
		.o_rd_ready(mem_rd_ready),
		.o_rdata_valid(mem_rdata_valid),
		.o_rdata(mem_rdata),
		.i_wr_valid(mem_wr_valid),
		.i_wr_addr(mem_wr_addr),
		.i_wr_data(mem_wr_data),
		.o_wr_ready(mem_wr_ready),
		.o_wr_ack(mem_wr_ack),
		.o_rd_bursts(rd_bursts),
		.o_wr_count(wr_count)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// Budget grows with the number of operations in the data file
	initial begin
		wait (num_ops > 0);
		repeat (CYCLES_PER_OP * num_ops + 20) @(posedge clk_i);
		$display("TB FAILED");
		$fatal(1, "test run did not finish within %0d cycles", CYCLES_PER_OP * num_ops + 20);
	end

	task automatic fail_run(input string why);
		$display("TB FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks_done++;
		assert (got === expected) else begin
			$display("ERROR %s: got %08h expected %08h at op %0d", name, got, expected, op_idx);
			fail_run("value mismatch");
		end
	endtask

	// Latency counts edges from the accept edge to the edge that sees the response
	task automatic send_request(input logic write, input logic cacheable, input addr_t addr,
		input word_t wdata, output int latency, output word_t rdata);
		req_valid <= 1'b1;
		req_write <= write;
		req_cacheable <= cacheable;
		req_addr <= addr;
		req_wdata <= wdata;
		do @(posedge clk_i); while (!req_ready);
		req_valid <= 1'b0;
		latency = 0;
		do begin
			@(posedge clk_i);
			latency++;
		end while (!rsp_valid);
		rdata = rsp_rdata;
	endtask

	// Only strobe once the cache is idle and the snoop unit is free
	task automatic pulse_snoop(input addr_t addr);
		do @(posedge clk_i); while (!req_ready);
		snoop_valid <= 1'b1;
		snoop_addr <= addr;
		@(posedge clk_i);
		snoop_valid <= 1'b0;
		// Busy spans the two cycles that follow the accepted strobe
		repeat (2) begin
			@(posedge clk_i);
			check_value("o_snoop_busy", {31'd0, snoop_busy}, 32'd1);
		end
		@(posedge clk_i);
		check_value("o_snoop_busy", {31'd0, snoop_busy}, 32'd0);
	endtask

	initial begin
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] expected;
		logic [31:0] bursts;
		word_t rdata;
		int latency;
		int prev_bursts;
		int writes;
		int count;

		void'($urandom(SEED));
		rst_n <= 1'b0;
		req_valid <= 1'b0;
		req_write <= 1'b0;
		req_cacheable <= 1'b0;
		req_addr <= '0;
		req_wdata <= '0;
		snoop_valid <= 1'b0;
		snoop_addr <= '0;

		for (int i = 0; i < MAX_OPS * COLS; i++) begin
			op_table[i] = END_MARK;
		end
		$readmemh("tests/cache_testdata.hex", op_table);
		count = 0;
		while (count < MAX_OPS && op_table[count * COLS] != END_MARK) begin
			count++;
		end
		if (count == 0) begin
			fail_run("the data file holds no operations");
		end
		num_ops = count;

		repeat (4) @(posedge clk_i);
		rst_n <= 1'b1;
		@(posedge clk_i);
		check_value("{o_req_ready,o_rsp_valid,o_mem_rd_valid,o_mem_wr_valid,o_snoop_busy}",
			{27'd0, req_ready, rsp_valid, mem_rd_valid, mem_wr_valid, snoop_busy}, 32'h10);

		prev_bursts = 0;
		writes = 0;
		for (int n = 0; n < num_ops; n++) begin
			op_idx = n;
			op = op_table[n * COLS];
			addr = op_table[n * COLS + 1];
			wdata = op_table[n * COLS + 2];
			expected = op_table[n * COLS + 3];
			bursts = op_table[n * COLS + 4];
			case (op)
				OP_READ, OP_UNCACHED: begin
					send_request(1'b0, op == OP_READ, addr, wdata, latency, rdata);
					check_value("o_rsp_rdata", rdata, expected);
					// A cacheable read with no new burst is a hit
					if (op == OP_READ && int'(bursts) == prev_bursts) begin
						check_value("hit latency", latency, HIT_LATENCY);
					end
				end
				OP_WRITE: begin
					send_request(1'b1, 1'b1, addr, wdata, latency, rdata);
					writes++;
					check_value("memory write count", wr_count, writes);
				end
				OP_SNOOP: pulse_snoop(addr);
				default: fail_run($sformatf("unknown operation %0h in the data file at op %0d",
					op, n));
			endcase
			check_value("memory read bursts", rd_bursts, bursts);
			prev_bursts = int'(bursts);
		end

		if (checks_done > 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "no checks were run");
		end
	end

endmodule

// ==== tests/cache_testdata.hex ====
// op addr wdata expected_rdata bursts, one operation per line, every field in hex
// op 0 read, 1 write, 2 uncached read, 3 snoop; bursts is the running read-burst total
0 00001004 00000000 5a5a1004 00000001
0 0000100c 00000000 5a5a100c 00000001
0 00001000 00000000 5a5a1000 00000001
0 00002008 00000000 5a5a2008 00000002
0 00003000 00000000 5a5a3000 00000003
0 00004004 00000000 5a5a4004 00000004
0 00001008 00000000 5a5a1008 00000004
0 0000400c 00000000 5a5a400c 00000004
1 00001008 deadbeef 00000000 00000004
0 00001008 00000000 deadbeef 00000004
0 00001004 00000000 5a5a1004 00000004
1 00005010 12345678 00000000 00000004
0 00005010 00000000 12345678 00000005
0 00005014 00000000 5a5a5014 00000005
3 00002000 00000000 00000000 00000005
0 00002008 00000000 5a5a2008 00000006
0 00002004 00000000 5a5a2004 00000006
3 00007000 00000000 00000000 00000006
0 00003004 00000000 5a5a3004 00000006
2 00006020 00000000 5a5a6020 00000007
0 00006024 00000000 5a5a6024 00000008
2 00001008 00000000 deadbeef 00000009
1 00006028 cafef00d 00000000 00000009
0 00006028 00000000 cafef00d 00000009
2 00006028 00000000 cafef00d 0000000a
0 0000a01c 00000000 5a5aa01c 0000000b
0 0000a010 00000000 5a5aa010 0000000b

// ==== flist.f ====
design/cache_bus_pkg.sv
design/cache_cfg_pkg.sv
design/sram_dualport.sv
design/way_lookup.sv
design/snoop_invalidate.sv
design/rw_controller.sv
design/l1_cache_top.sv
tests/tb_mem_model.sv
tests/tb_l1_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the L1 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_l1_cache -f flist.f \
	--Mdir obj_dir -o sim_l1_cache
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_l1_cache
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0
